//--- bpu_pkg.sv
package bpu_pkg;

    // core widths
    localparam int XLEN       = 32;
    localparam int HIST_WIDTH = 16;

    // direction tables
    localparam int BIMODAL_ENTRIES  = 512;
    localparam int TAGE_ENTRIES     = 256;
    localparam int TAG_WIDTH        = 10;
    localparam int PARTIAL_TAG_BITS = 6;   // upper tag bits compared on lookup

    // target buffer and return stack
    localparam int BTB_ENTRIES   = 256;
    localparam int BTB_TAG_WIDTH = 22;
    localparam int RAS_DEPTH     = 32;
    localparam int RAS_PTR_WIDTH = $clog2(RAS_DEPTH) + 1;   // holds RAS_DEPTH when full

    typedef logic [XLEN-1:0]                    addr_t;
    typedef logic [XLEN-1:0]                    inst_t;
    typedef logic [HIST_WIDTH-1:0]              hist_t;
    typedef logic [1:0]                         ctr_t;
    typedef logic [TAG_WIDTH-1:0]               tage_tag_t;
    typedef logic [BTB_TAG_WIDTH-1:0]           btb_tag_t;
    typedef logic [RAS_PTR_WIDTH-1:0]           ras_ptr_t;
    typedef logic [$clog2(BIMODAL_ENTRIES)-1:0] bim_idx_t;
    typedef logic [$clog2(TAGE_ENTRIES)-1:0]    tage_idx_t;
    typedef logic [$clog2(BTB_ENTRIES)-1:0]     btb_idx_t;
    typedef logic [$clog2(RAS_DEPTH)-1:0]       ras_idx_t;
    typedef logic [6:0]                         opcode_t;
    typedef logic [4:0]                         reg_idx_t;

    // rv32i major opcodes
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;

    // 2-bit saturating counter states
    localparam ctr_t CTR_STRONG_NT = 2'b00;
    localparam ctr_t CTR_WEAK_NT   = 2'b01;   // bimodal reset value
    localparam ctr_t CTR_WEAK_T    = 2'b10;
    localparam ctr_t CTR_STRONG_T  = 2'b11;

    // link registers, x1 and x5
    localparam reg_idx_t REG_RA = 5'd1;
    localparam reg_idx_t REG_T0 = 5'd5;

endpackage

//--- bpu_update_if.sv
`timescale 1ns/100ps

interface bpu_update_if import bpu_pkg::*; ();

    // execute feedback
    logic  valid;
    logic  taken;
    logic  pdt_true;     // fetch prediction was correct
    addr_t pc;
    addr_t target;
    inst_t inst;
    hist_t history;      // history seen at lookup time

    // pipeline stall, gates stack traffic only
    logic  stall;

    // decode-stage call push
    logic  push_valid;
    addr_t push_data;

    modport src (
        output valid, taken, pdt_true, pc, target, inst, history,
        output stall, push_valid, push_data
    );

    modport tage (input valid, taken, pdt_true, pc, history);

    modport btb (input valid, taken, pc, target);

    modport ras (input valid, taken, inst, stall, push_valid, push_data);

endinterface

//--- tage_direction.sv
`timescale 1ns/100ps

module tage_direction import bpu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    bpu_update_if.tage upd,
    input  addr_t      pc_i,
    output logic       pred_taken_o,
    output hist_t      history_o
);

    hist_t     ghist;

    ctr_t      bim_ctr [BIMODAL_ENTRIES];
    tage_tag_t t0_tag  [TAGE_ENTRIES];
    ctr_t      t0_ctr  [TAGE_ENTRIES];
    logic      t0_vld  [TAGE_ENTRIES];
    tage_tag_t t1_tag  [TAGE_ENTRIES];
    ctr_t      t1_ctr  [TAGE_ENTRIES];
    logic      t1_vld  [TAGE_ENTRIES];

    // lookup side
    tage_idx_t t0_idx_l, t1_idx_l;
    bim_idx_t  bim_idx_l;
    logic      t0_hit_l, t1_hit_l;

    // training side
    tage_idx_t t0_idx_u, t1_idx_u;
    tage_tag_t t0_tag_u, t1_tag_u;
    bim_idx_t  bim_idx_u;
    logic      t0_hit_u, t1_hit_u;
    logic      bim_miss, t1_free, alloc_t1, alloc_t0;

    // short history folds into T0, long history into T1
    function automatic tage_idx_t t0_index(input addr_t pc, input hist_t h);
        return pc[7:0] ^ h[7:0];
    endfunction

    function automatic tage_idx_t t1_index(input addr_t pc, input hist_t h);
        return pc[7:0] ^ h[15:8];
    endfunction

    function automatic tage_tag_t t0_tag_of(input addr_t pc, input hist_t h);
        return pc[17:8] ^ h[15:6];
    endfunction

    function automatic tage_tag_t t1_tag_of(input addr_t pc, input hist_t h);
        return pc[17:8] ^ {2'b00, h[7:0]};
    endfunction

    function automatic logic tag_hit(input tage_tag_t stored, input tage_tag_t probe);
        return stored[TAG_WIDTH-1 -: PARTIAL_TAG_BITS] == probe[TAG_WIDTH-1 -: PARTIAL_TAG_BITS];
    endfunction

    function automatic ctr_t ctr_step(input ctr_t c, input logic taken);
        if (taken)
            return (c == CTR_STRONG_T) ? c : c + 2'd1;
        return (c == CTR_STRONG_NT) ? c : c - 2'd1;
    endfunction

    assign history_o = ghist;

    assign bim_idx_l = pc_i[9:1];
    assign t0_idx_l  = t0_index(pc_i, ghist);
    assign t1_idx_l  = t1_index(pc_i, ghist);
    assign t0_hit_l  = t0_vld[t0_idx_l] && tag_hit(t0_tag[t0_idx_l], t0_tag_of(pc_i, ghist));
    assign t1_hit_l  = t1_vld[t1_idx_l] && tag_hit(t1_tag[t1_idx_l], t1_tag_of(pc_i, ghist));

    always_comb begin
        if (t1_hit_l)
            pred_taken_o = t1_ctr[t1_idx_l][1];
        else if (t0_hit_l)
            pred_taken_o = t0_ctr[t0_idx_l][1];
        else
            pred_taken_o = bim_ctr[bim_idx_l][1];   // base prediction
    end

    // provider recomputed from the history carried with the update
    assign bim_idx_u = upd.pc[9:1];
    assign t0_idx_u  = t0_index(upd.pc, upd.history);
    assign t1_idx_u  = t1_index(upd.pc, upd.history);
    assign t0_tag_u  = t0_tag_of(upd.pc, upd.history);
    assign t1_tag_u  = t1_tag_of(upd.pc, upd.history);
    assign t0_hit_u  = t0_vld[t0_idx_u] && tag_hit(t0_tag[t0_idx_u], t0_tag_u);
    assign t1_hit_u  = t1_vld[t1_idx_u] && tag_hit(t1_tag[t1_idx_u], t1_tag_u);

    assign bim_miss = upd.valid && !upd.pdt_true && !t1_hit_u && !t0_hit_u;
    assign t1_free  = !t1_vld[t1_idx_u] || (t1_tag[t1_idx_u] != t1_tag_u);
    assign alloc_t1 = bim_miss && t1_free;
    assign alloc_t0 = bim_miss && !t1_free;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist <= '0;
            for (int i = 0; i < BIMODAL_ENTRIES; i++)
                bim_ctr[i] <= CTR_WEAK_NT;
            for (int i = 0; i < TAGE_ENTRIES; i++) begin
                t0_vld[i] <= 1'b0;
                t1_vld[i] <= 1'b0;
            end
        end else if (upd.valid) begin
            ghist <= {ghist[HIST_WIDTH-2:0], upd.taken};   // newest outcome in bit 0
            bim_ctr[bim_idx_u] <= ctr_step(bim_ctr[bim_idx_u], upd.taken);
            if (alloc_t1)
                t1_vld[t1_idx_u] <= 1'b1;
            if (alloc_t0)
                t0_vld[t0_idx_u] <= 1'b1;
        end
    end

    // tagged entry payload
    always_ff @(posedge clk) begin
        if (upd.valid) begin
            if (upd.pdt_true) begin
                if (t1_hit_u)
                    t1_ctr[t1_idx_u] <= ctr_step(t1_ctr[t1_idx_u], upd.taken);
                else if (t0_hit_u)
                    t0_ctr[t0_idx_u] <= ctr_step(t0_ctr[t0_idx_u], upd.taken);
            end else if (t1_hit_u) begin
                t1_ctr[t1_idx_u] <= upd.taken ? CTR_STRONG_T : CTR_STRONG_NT;
            end else if (t0_hit_u) begin
                t0_ctr[t0_idx_u] <= upd.taken ? CTR_STRONG_T : CTR_STRONG_NT;
            end else if (alloc_t1) begin
                t1_tag[t1_idx_u] <= t1_tag_u;
                t1_ctr[t1_idx_u] <= upd.taken ? CTR_WEAK_T : CTR_WEAK_NT;
            end else begin
                // T1 already holds this tag
                t0_tag[t0_idx_u] <= t0_tag_u;
                t0_ctr[t0_idx_u] <= upd.taken ? CTR_WEAK_T : CTR_WEAK_NT;
            end
        end
    end

endmodule

//--- branch_target_buffer.sv
`timescale 1ns/100ps

module branch_target_buffer import bpu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    bpu_update_if.btb upd,
    input  addr_t     pc_i,
    output logic      hit_o,
    output addr_t     target_o
);

    btb_tag_t btb_tag [BTB_ENTRIES];
    addr_t    btb_tgt [BTB_ENTRIES];
    logic     btb_vld [BTB_ENTRIES];

    btb_idx_t rd_idx;
    btb_idx_t wr_idx;
    btb_tag_t rd_tag;
    logic     wr_en;

    // direct mapped, word aligned index
    assign rd_idx = pc_i[9:2];
    assign rd_tag = pc_i[31:10];

    assign hit_o    = btb_vld[rd_idx] && (btb_tag[rd_idx] == rd_tag);
    assign target_o = btb_tgt[rd_idx];

    assign wr_idx = upd.pc[9:2];
    assign wr_en  = upd.valid && upd.taken;   // only taken branches fill

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BTB_ENTRIES; i++)
                btb_vld[i] <= 1'b0;
        end else if (wr_en) begin
            btb_vld[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            btb_tag[wr_idx] <= upd.pc[31:10];
            btb_tgt[wr_idx] <= upd.target;
        end
    end

endmodule

//--- return_addr_stack.sv
`timescale 1ns/100ps

module return_addr_stack import bpu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    bpu_update_if.ras upd,
    output addr_t     top_o,
    output logic      nonempty_o
);

    addr_t    stack [RAS_DEPTH];
    ras_ptr_t sp;          // next free slot
    ras_ptr_t sp_pop;      // pointer after this cycle's pop
    ras_ptr_t sp_next;
    reg_idx_t ex_rs1;
    logic     ex_is_ret;
    logic     do_pop;
    logic     do_push;

    // return retiring in execute, jalr through ra or t0
    assign ex_rs1    = upd.inst[19:15];
    assign ex_is_ret = (upd.inst[6:0] == OPC_JALR) && (ex_rs1 == REG_RA || ex_rs1 == REG_T0);

    // pop first, push lands on the slot the pop freed
    assign do_pop  = upd.valid && upd.taken && ex_is_ret && !upd.stall && (sp != '0);
    assign sp_pop  = do_pop ? sp - ras_ptr_t'(1) : sp;
    assign do_push = upd.push_valid && !upd.stall && (sp_pop < ras_ptr_t'(RAS_DEPTH));
    assign sp_next = do_push ? sp_pop + ras_ptr_t'(1) : sp_pop;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            sp <= '0;
        else
            sp <= sp_next;
    end

    always_ff @(posedge clk) begin
        if (do_push)
            stack[ras_idx_t'(sp_pop)] <= upd.push_data;
    end

    // registered top only, no bypass of this cycle's traffic
    assign top_o      = stack[ras_idx_t'(sp - ras_ptr_t'(1))];
    assign nonempty_o = (sp != '0);

endmodule

//--- next_pc_select.sv
`timescale 1ns/100ps

module next_pc_select import bpu_pkg::*; (
    input  addr_t pc_i,
    input  inst_t inst_i,
    input  logic  pred_taken_i,
    input  logic  btb_hit_i,
    input  addr_t btb_target_i,
    input  addr_t ras_top_i,
    input  logic  ras_nonempty_i,
    output logic  branch_o,
    output logic  taken_o,
    output addr_t next_pc_o
);

    opcode_t  opcode;
    reg_idx_t rd;
    reg_idx_t rs1;
    logic     is_branch;
    logic     is_jal;
    logic     is_jalr;
    logic     is_ret;
    addr_t    pc_plus4;
    addr_t    imm_j;
    addr_t    imm_b;

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign rs1    = inst_i[19:15];

    assign is_branch = (opcode == OPC_BRANCH);
    assign is_jal    = (opcode == OPC_JAL);
    assign is_jalr   = (opcode == OPC_JALR);

    // jalr x0, 0(ra) or 0(t0)
    assign is_ret = is_jalr && (rd == '0) && (rs1 == REG_RA || rs1 == REG_T0)
                    && (inst_i[31:20] == 12'h000);

    assign pc_plus4 = pc_i + 32'd4;
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

    always_comb begin
        branch_o  = 1'b0;
        taken_o   = 1'b0;
        next_pc_o = pc_plus4;
        if (is_branch || is_jal || is_jalr) begin
            branch_o = 1'b1;
            if (is_ret) begin
                // empty stack falls through as not taken
                if (ras_nonempty_i) begin
                    taken_o   = 1'b1;
                    next_pc_o = ras_top_i;
                end
            end else if (is_jal) begin
                taken_o   = 1'b1;
                next_pc_o = btb_hit_i ? btb_target_i : pc_i + imm_j;
            end else begin
                taken_o = pred_taken_i;   // conditional or indirect jalr
                if (pred_taken_i) begin
                    if (btb_hit_i)
                        next_pc_o = btb_target_i;
                    else if (is_branch)
                        next_pc_o = pc_i + imm_b;
                end
            end
        end
    end

endmodule

//--- bpu_top.sv
`timescale 1ns/100ps

module bpu_top import bpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,

    // fetch
    input  addr_t if_pc_i,
    input  inst_t if_inst_i,

    // execute feedback
    input  logic  ex_branch_valid_i,
    input  logic  ex_branch_taken_i,
    input  logic  ex_pdt_true_i,
    input  addr_t ex_pc_i,
    input  hist_t ex_history_i,
    input  addr_t ex_target_i,
    input  inst_t ex_inst_i,

    // decode call push
    input  logic  id_ras_push_valid_i,
    input  addr_t id_ras_push_data_i,
    input  logic  ex_stall_valid_i,

    output logic  branch_or_not_o,
    output addr_t pdt_pc_o,
    output logic  pdt_res_o,
    output hist_t history_o
);

    logic  pred_taken;
    logic  btb_hit;
    addr_t btb_target;
    addr_t ras_top;
    logic  ras_nonempty;

    bpu_update_if upd ();

    // source side of the update bus
    assign upd.valid      = ex_branch_valid_i;
    assign upd.taken      = ex_branch_taken_i;
    assign upd.pdt_true   = ex_pdt_true_i;
    assign upd.pc         = ex_pc_i;
    assign upd.target     = ex_target_i;
    assign upd.inst       = ex_inst_i;
    assign upd.history    = ex_history_i;
    assign upd.stall      = ex_stall_valid_i;
    assign upd.push_valid = id_ras_push_valid_i;
    assign upd.push_data  = id_ras_push_data_i;

    tage_direction u_tage (
        .clk          (clk),
        .rst          (rst),
        .upd          (upd.tage),
        .pc_i         (if_pc_i),
        .pred_taken_o (pred_taken),
        .history_o    (history_o)
    );

    branch_target_buffer u_btb (
        .clk      (clk),
        .rst      (rst),
        .upd      (upd.btb),
        .pc_i     (if_pc_i),
        .hit_o    (btb_hit),
        .target_o (btb_target)
    );

    return_addr_stack u_ras (
        .clk        (clk),
        .rst        (rst),
        .upd        (upd.ras),
        .top_o      (ras_top),
        .nonempty_o (ras_nonempty)
    );

    next_pc_select u_sel (
        .pc_i           (if_pc_i),
        .inst_i         (if_inst_i),
        .pred_taken_i   (pred_taken),
        .btb_hit_i      (btb_hit),
        .btb_target_i   (btb_target),
        .ras_top_i      (ras_top),
        .ras_nonempty_i (ras_nonempty),
        .branch_o       (branch_or_not_o),
        .taken_o        (pdt_res_o),
        .next_pc_o      (pdt_pc_o)
    );

endmodule

//--- tb_bpu_tests.svh
task automatic decode_after_reset();
    int    start;
    addr_t br_pc;
    addr_t alu_pc;
    start  = errors;
    br_pc  = pc_for_slot(8'd1);
    alu_pc = pc_for_slot(8'd2);
    expect_pred(br_pc, encode_branch(13'h040), 1'b1, 1'b0, br_pc + 32'd4);
    check_value("history_o", 32'(last_hist), 32'h0);
    expect_pred(alu_pc, ADDI_INST, 1'b0, 1'b0, alu_pc + 32'd4);
    report_test("decode after reset", start);
endtask

task automatic train_direction();
    int    start;
    addr_t pc;
    addr_t tgt;
    inst_t inst;
    start = errors;
    pc    = pc_for_slot(8'd3);
    tgt   = rand_addr();
    inst  = encode_branch(13'h100);
    expect_pred(pc, inst, 1'b1, 1'b0, pc + 32'd4);   // bimodal weak not taken
    // bimodal mispredicts, T1 gets a weak taken entry
    set_update(pc, inst, 1'b1, 1'b0, tgt, '0);
    commit();
    expect_pred(pc, inst, 1'b1, 1'b1, tgt);
    set_update(pc, inst, 1'b0, 1'b0, tgt, '0);   // T1 wrong, goes strong not taken
    commit();
    expect_pred(pc, inst, 1'b1, 1'b0, pc + 32'd4);
    // bimodal falls back to not taken while T1 goes strong taken
    set_update(pc, inst, 1'b0, 1'b1, tgt, '0);
    commit();
    set_update(pc, inst, 1'b1, 1'b0, tgt, '0);
    commit();
    expect_pred(pc, inst, 1'b1, 1'b1, tgt);   // only T1 says taken
    check_value("history_o", 32'(last_hist), 32'(exp_hist));
    report_test("direction training", start);
endtask

task automatic jal_and_btb_fill();
    int          start;
    addr_t       pc;
    addr_t       tgt;
    inst_t       inst;
    logic [20:0] off;
    start  = errors;
    pc     = pc_for_slot(8'd4);
    tgt    = rand_addr();
    off    = 21'($urandom());
    off[0] = 1'b0;
    inst   = encode_jal(REG_RA, off);
    expect_pred(pc, inst, 1'b1, 1'b1, pc + {{11{off[20]}}, off});
    set_update(pc, inst, 1'b1, 1'b1, tgt, last_hist);
    commit();
    expect_pred(pc, inst, 1'b1, 1'b1, tgt);   // btb hit now wins
    report_test("jal and btb", start);
endtask

task automatic shift_history();
    int          start;
    addr_t       pc;
    logic [31:0] r;
    start = errors;
    pc    = pc_for_slot(8'd5);
    for (int i = 0; i < 20; i++) begin
        r = $urandom();
        set_update(pc, encode_branch(13'h020), r[0], 1'b1, pc + 32'd32, history_o);
        commit();
        check_value("history_o", 32'(history_o), 32'(exp_hist));
    end
    report_test("global history", start);
endtask

task automatic return_stack_order();
    int    start;
    addr_t pc;
    addr_t a;
    addr_t b;
    addr_t c;
    start = errors;
    pc    = pc_for_slot(8'd6);
    a     = rand_addr();
    b     = rand_addr();
    c     = rand_addr();
    expect_pred(pc, RET_INST, 1'b1, 1'b0, pc + 32'd4);   // empty stack
    set_push(a);
    commit();
    set_push(b);
    commit();
    expect_pred(pc, RET_INST, 1'b1, 1'b1, b);
    set_update(pc, RET_INST, 1'b1, 1'b1, b, last_hist);
    commit();
    expect_pred(pc, RET_INST, 1'b1, 1'b1, a);
    // pop and push together, c replaces a
    set_update(pc, RET_INST, 1'b1, 1'b1, a, last_hist);
    set_push(c);
    commit();
    expect_pred(pc, RET_INST, 1'b1, 1'b1, c);
    set_update(pc, RET_INST, 1'b1, 1'b1, c, last_hist);
    commit();
    expect_pred(pc, RET_INST, 1'b1, 1'b0, pc + 32'd4);
    report_test("return stack", start);
endtask

task automatic stall_and_full_stack();
    int    start;
    addr_t pc;
    addr_t c;
    addr_t last;
    start = errors;
    pc    = pc_for_slot(8'd7);
    c     = rand_addr();
    last  = c;
    set_push(c);
    commit();
    ex_stall_valid_i = 1'b1;
    set_update(pc, RET_INST, 1'b1, 1'b1, c, history_o);
    set_push(rand_addr());
    commit();
    ex_stall_valid_i = 1'b0;
    expect_pred(pc, RET_INST, 1'b1, 1'b1, c);
    check_value("history_o", 32'(last_hist), 32'(exp_hist));   // history trains under stall
    for (int i = 0; i < RAS_DEPTH - 1; i++) begin
        last = rand_addr();
        set_push(last);
        commit();
    end
    expect_pred(pc, RET_INST, 1'b1, 1'b1, last);
    set_push(last + 32'd4);   // stack full, dropped
    commit();
    expect_pred(pc, RET_INST, 1'b1, 1'b1, last);
    report_test("stall and full stack", start);
endtask

//--- tb_bpu_top.sv
`timescale 1ns/100ps

module tb_bpu_top import bpu_pkg::*; ();

    localparam int          TIMEOUT_CYCLES = 2000;   // all tests finish well under 300
    localparam logic [31:0] RAND_SEED      = 32'he3fc_00b9;
    localparam inst_t       ADDI_INST      = 32'h0050_0093;   // addi x1, x0, 5
    localparam inst_t       RET_INST       = 32'h0000_8067;   // jalr x0, 0(ra)

    logic  clk;
    logic  rst;
    addr_t if_pc_i;
    inst_t if_inst_i;
    logic  ex_branch_valid_i, ex_branch_taken_i, ex_pdt_true_i;
    addr_t ex_pc_i, ex_target_i;
    hist_t ex_history_i;
    inst_t ex_inst_i;
    logic  id_ras_push_valid_i;
    addr_t id_ras_push_data_i;
    logic  ex_stall_valid_i;
    logic  branch_or_not_o;
    addr_t pdt_pc_o;
    logic  pdt_res_o;
    hist_t history_o;

    int    errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    cycle_count = 0;
    hist_t exp_hist = '0;    // expected global history
    hist_t last_hist = '0;   // history_o seen at the latest lookup

    bpu_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the tests did not complete", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic idle_inputs();
        if_pc_i             = '0;
        if_inst_i           = '0;
        ex_branch_valid_i   = 1'b0;
        ex_branch_taken_i   = 1'b0;
        ex_pdt_true_i       = 1'b0;
        ex_pc_i             = '0;
        ex_history_i        = '0;
        ex_target_i         = '0;
        ex_inst_i           = '0;
        id_ras_push_valid_i = 1'b0;
        id_ras_push_data_i  = '0;
        ex_stall_valid_i    = 1'b0;
    endtask

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAIL %s got 0x%08h expected 0x%08h", name, got, expected);
            errors++;
        end
    endtask

    task automatic expect_pred(input addr_t pc, input inst_t inst, input logic exp_branch,
                               input logic exp_taken, input addr_t exp_pc);
        if_pc_i   = pc;
        if_inst_i = inst;
        #2;   // mid cycle, outputs settled
        last_hist = history_o;
        check_value("branch_or_not_o", 32'(branch_or_not_o), 32'(exp_branch));
        check_value("pdt_res_o", 32'(pdt_res_o), 32'(exp_taken));
        check_value("pdt_pc_o", pdt_pc_o, exp_pc);
        next_cycle();
    endtask

    task automatic set_update(input addr_t pc, input inst_t inst, input logic taken,
                              input logic pdt_true, input addr_t target, input hist_t hist);
        ex_branch_valid_i = 1'b1;
        ex_branch_taken_i = taken;
        ex_pdt_true_i     = pdt_true;
        ex_pc_i           = pc;
        ex_inst_i         = inst;
        ex_target_i       = target;
        ex_history_i      = hist;
        exp_hist = {exp_hist[HIST_WIDTH-2:0], taken};   // newest outcome in bit 0
    endtask

    task automatic set_push(input addr_t data);
        id_ras_push_valid_i = 1'b1;
        id_ras_push_data_i  = data;
    endtask

    // one clock edge takes the pending update and push
    task automatic commit();
        next_cycle();
        ex_branch_valid_i   = 1'b0;
        id_ras_push_valid_i = 1'b0;
    endtask

    task automatic report_test(input string name, input int start);
        tests_run++;
        if (errors == start) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d mismatches", name, errors - start);
        end
    endtask

    function automatic addr_t rand_addr();
        logic [31:0] r;
        r = $urandom();
        return {r[31:2], 2'b00};
    endfunction

    // slot picks both the btb index and the bimodal index
    function automatic addr_t pc_for_slot(input logic [7:0] slot);
        logic [31:0] r;
        r = $urandom();
        return {r[31:10], slot, 2'b00};
    endfunction

    function automatic inst_t encode_branch(input logic [12:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic inst_t encode_jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    `include "tb_bpu_tests.svh"

    initial begin
        void'($urandom(RAND_SEED));
        rst = 1'b1;
        idle_inputs();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        decode_after_reset();
        train_direction();   // needs zero history, so it runs first
        jal_and_btb_fill();
        shift_history();
        return_stack_order();
        stall_and_full_stack();

        $display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- bpu_top.f
+incdir+.
bpu_pkg.sv
bpu_update_if.sv
tage_direction.sv
branch_target_buffer.sv
return_addr_stack.sv
next_pc_select.sv
bpu_top.sv
tb_bpu_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the bpu testbench with verilator, result read from sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
    --top-module tb_bpu_top -f bpu_top.f -o tb_bpu_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_bpu_top > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "Simulation failed" sim.log; then
    echo "tests failed, see sim.log"
    exit 1
fi

echo "tests passed"
exit 0
